/* sim.f */
rtl/egr_axis_pkg.sv
rtl/egr_reg_pkg.sv
rtl/axis_skid.sv
rtl/axis_pkt_mux.sv
rtl/egr_lane.sv
rtl/egr_regs.sv
rtl/smartnic_egr.sv
tests/tb_smartnic_egr.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_smartnic_egr
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_smartnic_egr.sv */
`timescale 1ns/1ps

module tb_smartnic_egr;

    localparam int np = egr_reg_pkg::num_ports;
    localparam int n2 = 6;   // packets per source in the latency test.
    localparam int n3 = 8;   // packets per source in the contention test.
    localparam int n4 = 10;  // packets per source under back-pressure.
    localparam int n5 = 5;   // packets per source in the enable test.
    // worst case of 6 beats per packet, plus room for register traffic.
    localparam int plan_beats = 6 * (2 * n2 + 4 * n3 + 4 * n4 + 2 * n5) + 200;
    localparam int drain_cycles = 500;  // far more than the beats left in the lanes.

    logic                     core_clk = 1'b0;
    logic                     arst_n;
    logic [np-1:0]            core_valid, core_ready, h2c_valid, h2c_ready;
    logic [np-1:0]            out_valid, out_ready;
    egr_axis_pkg::axis_beat_t core_beat [np];
    egr_axis_pkg::axis_beat_t h2c_beat  [np];
    egr_axis_pkg::axis_beat_t out_beat  [np];
    egr_reg_pkg::axil_req_t   axil_req;
    egr_reg_pkg::axil_rsp_t   axil_rsp;

    int  seed = 32'h30fa;
    int  errors = 0;
    int  checks = 0;
    int  seq [2*np];      // next packet number per port and source.
    int  tb_cnt [np];     // tlast beats seen per port.
    bit  lat_on, alt_on, rdy_rand;
    bit  dis_on [np];     // host-to-card is disabled on this port.
    egr_axis_pkg::axis_beat_t exp_q [2*np][$];  // index is 2 * port + source.
    time acc_q [np][$];   // accept times of first beats for the latency check.

    always #5 core_clk = ~core_clk;

    smartnic_egr smartnic_egr_inst (
        .core_clk, .arst_n,
        .core_valid, .core_beat, .core_ready,
        .h2c_valid, .h2c_beat, .h2c_ready,
        .out_valid, .out_beat, .out_ready,
        .axil_req, .axil_rsp
    );

    always @(posedge core_clk) begin
        #1;
        for (int p = 0; p < np; p++) begin
            out_ready[p] = rdy_rand ? (($random(seed) & 3) != 0) : 1'b1;  // stall one in four.
        end
    end

    for (genvar p = 0; p < np; p++) begin : g_mon
        logic       in_pkt = 1'b0;  // a packet has started and not ended yet.
        logic [3:0] cur_tid;
        logic       prev_tid;
        bit         have_prev = 1'b0;
        egr_axis_pkg::axis_beat_t exp_b;

        always @(posedge core_clk) begin
            if (!alt_on) have_prev = 1'b0;
            if (arst_n && out_valid[p] && out_ready[p]) begin
                checks++;
                if (exp_q[2*p + out_beat[p].tid[0]].size() == 0) begin
                    errors++;
                    $display("port %0d sent beat %h that no source queued", p, out_beat[p].tdata);
                end else begin
                    exp_b = exp_q[2*p + out_beat[p].tid[0]].pop_front();
                    assert (out_beat[p] == exp_b) else begin
                        errors++;
                        $display("mismatch out_beat[%0d].tdata got %h exp %h",
                                 p, out_beat[p].tdata, exp_b.tdata);
                    end
                end
                if (in_pkt) begin
                    assert (out_beat[p].tid == cur_tid) else begin
                        errors++;
                        $display("mismatch out_beat[%0d].tid got %h exp %h",
                                 p, out_beat[p].tid, cur_tid);
                    end
                end else begin
                    cur_tid = out_beat[p].tid;  // first beat of a packet.
                    if (lat_on && acc_q[p].size() > 0) begin
                        assert ($time - acc_q[p][0] == 20) else begin
                            errors++;
                            $display("port %0d first beat took %0t instead of 2 cycles",
                                     p, $time - acc_q[p][0]);
                        end
                        void'(acc_q[p].pop_front());
                    end
                    assert (!(dis_on[p] && cur_tid == 4'd1)) else begin
                        errors++;
                        $display("port %0d started a host-to-card packet while disabled", p);
                    end
                    // the other source is well backed up, so it must get this turn.
                    if (alt_on && have_prev && exp_q[2*p + !prev_tid].size() >= 2) begin
                        assert (cur_tid[0] != prev_tid) else begin
                            errors++;
                            $display("port %0d served source %0d twice in a row", p, prev_tid);
                        end
                    end
                    prev_tid  = cur_tid[0];
                    have_prev = 1'b1;
                end
                in_pkt = !out_beat[p].tlast;
                if (out_beat[p].tlast) tb_cnt[p]++;
            end
        end

        hold_chk: assert property (@(posedge core_clk) disable iff (!arst_n)
            out_valid[p] && !out_ready[p] |=> $stable(out_beat[p]))
            else begin
                errors++;
                $display("mismatch out_beat[%0d].tdata got %h exp %h", p,
                         out_beat[p].tdata, $past(out_beat[p].tdata));
            end
    end

    function automatic logic src_ready(input int p, input int s);
        return (s == 0) ? core_ready[p] : h2c_ready[p];
    endfunction

    function automatic int queued();
        int n;
        n = 0;
        for (int i = 0; i < 2 * np; i++) n += exp_q[i].size();
        return n;
    endfunction

    task automatic drive(input int p, input int s, input logic v,
                         input egr_axis_pkg::axis_beat_t b);
        if (s == 0) begin
            core_valid[p] = v;
            core_beat[p]  = b;
        end else begin
            h2c_valid[p] = v;
            h2c_beat[p]  = b;
        end
    endtask

    // sends one packet of 1 to 6 beats, called 1 ns after a rising edge.
    task automatic send_pkt(input int p, input int s, input bit stall);
        int len;
        int n;
        egr_axis_pkg::axis_beat_t b;
        len = 1 + int'($unsigned($random(seed)) % 6);
        for (int i = 0; i < len; i++) begin
            b.tdata = {8'(p), 8'(s), 16'(seq[2*p+s]), 16'(i), 16'h5a5a};
            b.tkeep = 8'hff;
            b.tlast = (i == len - 1);
            b.tid   = 4'(s);
            b.tdest = 4'(p);
            b.tuser = 8'(seq[2*p+s]);
            exp_q[2*p+s].push_back(b);
            drive(p, s, 1'b1, b);
            do @(posedge core_clk); while (!src_ready(p, s));
            if (i == 0 && lat_on) acc_q[p].push_back($time);
            #1;
            drive(p, s, 1'b0, b);
            n = stall ? int'($unsigned($random(seed)) % 3) : 0;
            if (n > 0) begin
                repeat (n) @(posedge core_clk);
                #1;
            end
        end
        seq[2*p+s]++;
    endtask

    task automatic run_src(input int p, input int s, input int npkt, input bit stall);
        for (int k = 0; k < npkt; k++) send_pkt(p, s, stall);
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        do @(posedge core_clk); while (!(axil_rsp.awready && axil_rsp.wready));
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        do @(posedge core_clk); while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        do @(posedge core_clk); while (!axil_rsp.arready);
        #1;
        axil_req.arvalid = 1'b0;
        do @(posedge core_clk); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        #1;
        axil_req.rready = 1'b0;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("mismatch %s got %h exp %h", name, got, exp);
        end
    endtask

    // waits for the lanes to empty, then checks that every queued beat came out.
    task automatic drain();
        int waited;
        waited = 0;
        while (queued() != 0 && waited < drain_cycles) begin
            @(posedge core_clk);
            waited++;
        end
        repeat (4) @(posedge core_clk);
        #1;
        check_val("queued beats", 32'(queued()), 32'd0);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors so far", name, errors);
    endtask

    initial begin
        #(longint'(plan_beats) * 40 * 10);
        $display("watchdog expired at %0t with %0d beats still queued", $time, queued());
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [1:0]  rsp;
        arst_n     = 1'b0;
        core_valid = '0;
        h2c_valid  = '0;
        out_ready  = '1;
        axil_req   = '0;
        for (int p = 0; p < np; p++) begin
            core_beat[p] = '0;
            h2c_beat[p]  = '0;
        end
        repeat (8) @(posedge core_clk);
        #1;
        arst_n = 1'b1;
        repeat (2) @(posedge core_clk);
        #1;

        axil_read(egr_reg_pkg::reg_id_addr, rd, rsp);
        check_val("id rdata", rd, 32'h45475230);
        check_val("id rresp", 32'(rsp), 32'(egr_reg_pkg::resp_okay));
        axil_read(egr_reg_pkg::reg_ctrl_addr, rd, rsp);
        check_val("ctrl rdata", rd, 32'h0000000f);
        check_val("ctrl rresp", 32'(rsp), 32'(egr_reg_pkg::resp_okay));
        end_test("reset_values");

        lat_on = 1'b1;  // one source per port, so nothing contends.
        fork
            run_src(0, 0, n2, 1'b1);
            run_src(1, 1, n2, 1'b1);
        join
        drain();
        lat_on = 1'b0;
        end_test("single_source");

        alt_on = 1'b1;
        fork
            run_src(0, 0, n3, 1'b0);
            run_src(0, 1, n3, 1'b0);
            run_src(1, 0, n3, 1'b0);
            run_src(1, 1, n3, 1'b0);
        join
        drain();
        alt_on = 1'b0;
        end_test("contention");

        rdy_rand = 1'b1;
        fork
            run_src(0, 0, n4, 1'b1);
            run_src(0, 1, n4, 1'b1);
            run_src(1, 0, n4, 1'b1);
            run_src(1, 1, n4, 1'b1);
        join
        drain();
        rdy_rand = 1'b0;
        end_test("back_pressure");

        axil_write(egr_reg_pkg::reg_ctrl_addr, 32'h0000000d, rsp);  // port 0 host-to-card off.
        check_val("ctrl bresp", 32'(rsp), 32'(egr_reg_pkg::resp_okay));
        dis_on[0] = 1'b1;
        fork
            begin
                run_src(0, 0, n5, 1'b1);
                drain_core: while (exp_q[0].size() != 0) @(posedge core_clk);
                #1;
                check_val("held h2c beats", 32'(exp_q[1].size() > 0), 32'd1);
                dis_on[0] = 1'b0;
                axil_write(egr_reg_pkg::reg_ctrl_addr, 32'h0000000f, rsp);
            end
            run_src(0, 1, n5, 1'b1);
        join
        drain();
        end_test("source_enable");

        for (int p = 0; p < np; p++) begin
            axil_read(egr_reg_pkg::reg_cnt_base + 8'(4 * p), rd, rsp);
            check_val("pkt_cnt rdata", rd, 32'(tb_cnt[p]));
        end
        axil_write(egr_reg_pkg::reg_cnt_base + 8'd4, 32'h12345678, rsp);
        check_val("cnt clear bresp", 32'(rsp), 32'(egr_reg_pkg::resp_okay));
        axil_read(egr_reg_pkg::reg_cnt_base + 8'd4, rd, rsp);
        check_val("cleared pkt_cnt", rd, 32'd0);
        axil_read(8'h40, rd, rsp);
        check_val("unmapped rresp", 32'(rsp), 32'(egr_reg_pkg::resp_slverr));
        check_val("unmapped rdata", rd, 32'd0);
        end_test("counters");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* rtl/smartnic_egr.sv */
`timescale 1ns/1ps

module smartnic_egr (
    input  logic                              core_clk,
    input  logic                              arst_n,
    input  logic [egr_reg_pkg::num_ports-1:0] core_valid,
    input  egr_axis_pkg::axis_beat_t          core_beat [egr_reg_pkg::num_ports],
    output logic [egr_reg_pkg::num_ports-1:0] core_ready,
    input  logic [egr_reg_pkg::num_ports-1:0] h2c_valid,
    input  egr_axis_pkg::axis_beat_t          h2c_beat  [egr_reg_pkg::num_ports],
    output logic [egr_reg_pkg::num_ports-1:0] h2c_ready,
    output logic [egr_reg_pkg::num_ports-1:0] out_valid,
    output egr_axis_pkg::axis_beat_t          out_beat  [egr_reg_pkg::num_ports],
    input  logic [egr_reg_pkg::num_ports-1:0] out_ready,
    input  egr_reg_pkg::axil_req_t            axil_req,
    output egr_reg_pkg::axil_rsp_t            axil_rsp
);

    logic [1:0]                        src_en [egr_reg_pkg::num_ports];  // per-port source enables.
    logic [egr_reg_pkg::num_ports-1:0] pkt_done;                         // tlast transfers per port.

    // one block serves the mask to the lanes and counts their finished packets.
    egr_regs egr_regs_inst (
        .core_clk, .arst_n,
        .axil_req, .axil_rsp,
        .src_en, .pkt_done
    );

    for (genvar p = 0; p < egr_reg_pkg::num_ports; p++) begin : g_lane
        egr_lane egr_lane_inst (
            .core_clk, .arst_n,
            .core_valid (core_valid[p]), .core_beat (core_beat[p]), .core_ready (core_ready[p]),
            .h2c_valid  (h2c_valid[p]),  .h2c_beat  (h2c_beat[p]),  .h2c_ready  (h2c_ready[p]),
            .src_en     (src_en[p]),
            .out_valid  (out_valid[p]),  .out_beat  (out_beat[p]),  .out_ready  (out_ready[p]),
            .pkt_done   (pkt_done[p])
        );
    end

endmodule

/* rtl/egr_regs.sv */
`timescale 1ns/1ps

module egr_regs (
    input  logic                              core_clk,
    input  logic                              arst_n,
    input  egr_reg_pkg::axil_req_t            axil_req,
    output egr_reg_pkg::axil_rsp_t            axil_rsp,
    output logic [1:0]                        src_en [egr_reg_pkg::num_ports],
    input  logic [egr_reg_pkg::num_ports-1:0] pkt_done
);

    typedef enum logic [2:0] {
        st_idle,   // waiting for a request.
        st_wacc,   // awready and wready are high, the write lands.
        st_wresp,  // bvalid held until bready.
        st_racc,   // arready is high, read data is captured.
        st_rresp   // rvalid held until rready.
    } state_t;

    state_t                            state;
    logic [egr_reg_pkg::ctrl_wid-1:0]  ctrl_reg;                        // source enable mask.
    logic [31:0]                       pkt_cnt [egr_reg_pkg::num_ports]; // output packets per port.
    logic [1:0]                        bresp_q;   // response of the last write.
    logic [31:0]                       rdata_q;   // data of the last read.
    logic [1:0]                        rresp_q;   // response of the last read.
    logic                              wr_en;     // the write handshake happens this cycle.
    logic [7:0]                        wr_off;    // write address relative to the counters.
    logic [7:0]                        rd_off;    // read address relative to the counters.
    logic                              wr_cnt_hit;
    logic                              rd_cnt_hit;
    logic                              wr_err;    // write to an unmapped or read-only word.
    logic                              rd_err;    // read of an unmapped word.
    logic [31:0]                       rd_data;   // decoded read value.

    assign wr_en  = (state == st_wacc);
    assign wr_off = axil_req.awaddr - egr_reg_pkg::reg_cnt_base;
    assign rd_off = axil_req.araddr - egr_reg_pkg::reg_cnt_base;
    // counters are word aligned from the base, one per port.
    assign wr_cnt_hit = (axil_req.awaddr >= egr_reg_pkg::reg_cnt_base) && (wr_off[1:0] == 2'b00)
                        && (int'(wr_off[7:2]) < egr_reg_pkg::num_ports);
    assign rd_cnt_hit = (axil_req.araddr >= egr_reg_pkg::reg_cnt_base) && (rd_off[1:0] == 2'b00)
                        && (int'(rd_off[7:2]) < egr_reg_pkg::num_ports);
    // the id word is read-only, so a write to it is refused too.
    assign wr_err = !(wr_cnt_hit || (axil_req.awaddr == egr_reg_pkg::reg_ctrl_addr));

    always_comb begin
        rd_data = '0;  // unmapped reads return zero.
        rd_err  = 1'b0;
        if (axil_req.araddr == egr_reg_pkg::reg_id_addr) begin
            rd_data = egr_reg_pkg::id_value;
        end else if (axil_req.araddr == egr_reg_pkg::reg_ctrl_addr) begin
            rd_data = 32'(ctrl_reg);
        end else if (rd_cnt_hit) begin
            for (int p = 0; p < egr_reg_pkg::num_ports; p++) begin
                if (int'(rd_off[7:2]) == p) rd_data = pkt_cnt[p];
            end
        end else begin
            rd_err = 1'b1;
        end
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            ctrl_reg <= {egr_reg_pkg::ctrl_wid{1'b1}};  // every source enabled.
            for (int p = 0; p < egr_reg_pkg::num_ports; p++) pkt_cnt[p] <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (axil_req.awvalid && axil_req.wvalid) state <= st_wacc;  // writes first.
                    else if (axil_req.arvalid)               state <= st_racc;
                end
                st_wacc:  state <= st_wresp;
                st_wresp: if (axil_req.bready) state <= st_idle;
                st_racc:  state <= st_rresp;
                st_rresp: if (axil_req.rready) state <= st_idle;
                default:  state <= st_idle;
            endcase
            if (wr_en && (axil_req.awaddr == egr_reg_pkg::reg_ctrl_addr) && axil_req.wstrb[0]) begin
                ctrl_reg <= axil_req.wdata[egr_reg_pkg::ctrl_wid-1:0];  // mask fits in byte 0.
            end
            for (int p = 0; p < egr_reg_pkg::num_ports; p++) begin
                if (wr_en && wr_cnt_hit && (int'(wr_off[7:2]) == p)) begin
                    pkt_cnt[p] <= '0;  // a clear beats a packet ending in the same cycle.
                end else if (pkt_done[p]) begin
                    pkt_cnt[p] <= pkt_cnt[p] + 32'd1;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            bresp_q <= wr_err ? egr_reg_pkg::resp_slverr : egr_reg_pkg::resp_okay;
        end
        if (state == st_racc) begin
            rdata_q <= rd_data;  // held stable while rvalid waits for rready.
            rresp_q <= rd_err ? egr_reg_pkg::resp_slverr : egr_reg_pkg::resp_okay;
        end
    end

    always_comb begin
        for (int p = 0; p < egr_reg_pkg::num_ports; p++) begin
            src_en[p] = ctrl_reg[2*p +: 2];  // bit 0 core, bit 1 host-to-card.
        end
    end

    assign axil_rsp.awready = wr_en;
    assign axil_rsp.wready  = wr_en;
    assign axil_rsp.bvalid  = (state == st_wresp);
    assign axil_rsp.bresp   = bresp_q;
    assign axil_rsp.arready = (state == st_racc);
    assign axil_rsp.rvalid  = (state == st_rresp);
    assign axil_rsp.rdata   = rdata_q;
    assign axil_rsp.rresp   = rresp_q;

endmodule

/* rtl/egr_lane.sv */
`timescale 1ns/1ps

module egr_lane (
    input  logic                     core_clk,
    input  logic                     arst_n,
    input  logic                     core_valid,
    input  egr_axis_pkg::axis_beat_t core_beat,
    output logic                     core_ready,
    input  logic                     h2c_valid,
    input  egr_axis_pkg::axis_beat_t h2c_beat,
    output logic                     h2c_ready,
    input  logic [1:0]               src_en,
    output logic                     out_valid,
    output egr_axis_pkg::axis_beat_t out_beat,
    input  logic                     out_ready,
    output logic                     pkt_done
);

    logic [1:0]               mid_valid;  // input skid outputs, index 0 is core.
    egr_axis_pkg::axis_beat_t mid_beat [2];
    logic [1:0]               mid_ready;
    logic                     mux_valid;  // mux output into the output skid.
    egr_axis_pkg::axis_beat_t mux_beat;
    logic                     mux_ready;

    axis_skid #(.payload_t(egr_axis_pkg::axis_beat_t)) core_skid_inst (
        .core_clk, .arst_n,
        .in_valid  (core_valid),   .in_data  (core_beat),   .in_ready  (core_ready),
        .out_valid (mid_valid[0]), .out_data (mid_beat[0]), .out_ready (mid_ready[0])
    );

    axis_skid #(.payload_t(egr_axis_pkg::axis_beat_t)) h2c_skid_inst (
        .core_clk, .arst_n,
        .in_valid  (h2c_valid),    .in_data  (h2c_beat),    .in_ready  (h2c_ready),
        .out_valid (mid_valid[1]), .out_data (mid_beat[1]), .out_ready (mid_ready[1])
    );

    axis_pkt_mux axis_pkt_mux_inst (
        .core_clk, .arst_n,
        .in_valid  (mid_valid), .in_beat  (mid_beat), .in_en (src_en), .in_ready (mid_ready),
        .out_valid (mux_valid), .out_beat (mux_beat), .out_ready (mux_ready)
    );

    // second cycle of latency, and it isolates out_ready from the arbiter.
    axis_skid #(.payload_t(egr_axis_pkg::axis_beat_t)) out_skid_inst (
        .core_clk, .arst_n,
        .in_valid  (mux_valid), .in_data  (mux_beat), .in_ready  (mux_ready),
        .out_valid (out_valid), .out_data (out_beat), .out_ready (out_ready)
    );

    assign pkt_done = out_valid && out_ready && out_beat.tlast;  // one pulse per packet.

endmodule

/* rtl/axis_pkt_mux.sv */
`timescale 1ns/1ps

module axis_pkt_mux (
    input  logic                     core_clk,
    input  logic                     arst_n,
    input  logic [1:0]               in_valid,
    input  egr_axis_pkg::axis_beat_t in_beat [2],
    input  logic [1:0]               in_en,
    output logic [1:0]               in_ready,
    output logic                     out_valid,
    output egr_axis_pkg::axis_beat_t out_beat,
    input  logic                     out_ready
);

    logic [1:0] req;       // inputs that may be newly granted.
    logic       locked;    // a packet is in progress and owns the output.
    logic       last_sel;  // last granted input, which is also the owner while locked.
    logic       sel;       // input routed to the output this cycle.
    logic       out_xfer;  // a beat leaves the mux this cycle.

    assign req = in_valid & in_en;  // a disabled input cannot start a packet.

    always_comb begin
        if (locked) begin
            sel = last_sel;  // stay with the packet until its tlast.
        end else if (req[~last_sel]) begin
            sel = ~last_sel;  // the other input gets its turn first.
        end else begin
            sel = last_sel;
        end
    end

    // the owner finishes its packet even if its enable was cleared meanwhile.
    assign out_valid = locked ? in_valid[sel] : |req;
    assign out_beat  = in_beat[sel];
    assign out_xfer  = out_valid && out_ready;

    always_comb begin
        in_ready = 2'b00;
        in_ready[sel] = out_ready && (locked || req[sel]);  // only the granted input sees ready.
    end

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            locked   <= 1'b0;
            last_sel <= 1'b1;  // so the core input wins the first contest.
        end else begin
            last_sel <= sel;  // sel only moves when a new grant is taken.
            if (out_xfer && out_beat.tlast) begin
                locked <= 1'b0;  // packet done, arbitrate again next cycle.
            end else if (out_valid) begin
                locked <= 1'b1;  // lock as soon as a first beat is shown, so a stall keeps it.
            end
        end
    end

endmodule

/* rtl/axis_skid.sv */
`timescale 1ns/1ps

module axis_skid #(
    parameter type payload_t = egr_axis_pkg::axis_beat_t  // what one transfer carries.
) (
    input  logic     core_clk,
    input  logic     arst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    payload_t spare_data;   // catches the beat in flight when the output stalls.
    logic     spare_valid;  // the spare register holds a beat.
    logic     in_xfer;      // a beat is accepted at the input this cycle.
    logic     main_load;    // the main register is free or drains this cycle.
    logic     spare_nxt;    // spare occupancy for the next cycle.

    assign in_xfer   = in_valid && in_ready;
    assign main_load = !out_valid || out_ready;
    // the spare fills only when a beat arrives while the main register is stuck.
    assign spare_nxt = spare_valid ? !main_load : (in_xfer && !main_load);

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid   <= 1'b0;  // nothing to present.
            spare_valid <= 1'b0;  // spare is empty.
            in_ready    <= 1'b0;  // ready rises one cycle after reset.
        end else begin
            if (main_load) begin
                out_valid <= spare_valid || in_xfer;  // spare beat goes first.
            end
            spare_valid <= spare_nxt;
            in_ready    <= !spare_nxt;  // registered, low only while the spare is full.
        end
    end

    always_ff @(posedge core_clk) begin
        if (main_load) begin
            out_data <= spare_valid ? spare_data : in_data;  // keeps beat order.
        end
        if (!spare_valid) begin
            spare_data <= in_data;  // only counted as held when spare_nxt is set.
        end
    end

endmodule

/* rtl/egr_reg_pkg.sv */
package egr_reg_pkg;

    localparam int num_ports     = 2;                  // egress ports, one lane each.
    localparam int axil_addr_wid = 8;                  // register space is 256 bytes.
    localparam int axil_data_wid = 32;                 // register width.
    localparam int ctrl_wid      = 2 * num_ports;      // two source enables per port.

    localparam logic [axil_addr_wid-1:0] reg_id_addr   = 8'h00;  // read-only id word.
    localparam logic [axil_addr_wid-1:0] reg_ctrl_addr = 8'h04;  // source enable mask.
    localparam logic [axil_addr_wid-1:0] reg_cnt_base  = 8'h10;  // first packet counter.

    localparam logic [axil_data_wid-1:0] id_value = 32'h45475230;  // reads as "EGR0".

    localparam logic [1:0] resp_okay   = 2'd0;  // access completed.
    localparam logic [1:0] resp_slverr = 2'd2;  // access to an unmapped or read-only word.

    // signals driven by the AXI4-Lite master.
    typedef struct packed {
        logic                       awvalid;
        logic [axil_addr_wid-1:0]   awaddr;
        logic                       wvalid;
        logic [axil_data_wid-1:0]   wdata;
        logic [axil_data_wid/8-1:0] wstrb;
        logic                       bready;
        logic                       arvalid;
        logic [axil_addr_wid-1:0]   araddr;
        logic                       rready;
    } axil_req_t;

    // signals driven by the AXI4-Lite slave.
    typedef struct packed {
        logic                     awready;
        logic                     wready;
        logic                     bvalid;
        logic [1:0]               bresp;
        logic                     arready;
        logic                     rvalid;
        logic [axil_data_wid-1:0] rdata;
        logic [1:0]               rresp;
    } axil_rsp_t;

endpackage

/* rtl/egr_axis_pkg.sv */
package egr_axis_pkg;

    localparam int data_bytes = 8;                 // bytes carried by one stream beat.
    localparam int data_wid   = data_bytes * 8;    // tdata width in bits.
    localparam int tid_wid    = 4;                 // source id width.
    localparam int tdest_wid  = 4;                 // destination width.
    localparam int tuser_wid  = 8;                 // sideband user width.

    // one AXI4-Stream beat without its handshake, which travels beside it.
    typedef struct packed {
        logic [data_wid-1:0]   tdata;   // payload bytes.
        logic [data_bytes-1:0] tkeep;   // byte qualifiers for tdata.
        logic                  tlast;   // marks the final beat of a packet.
        logic [tid_wid-1:0]    tid;     // source of the packet.
        logic [tdest_wid-1:0]  tdest;   // routing hint carried unchanged.
        logic [tuser_wid-1:0]  tuser;   // user sideband carried unchanged.
    } axis_beat_t;

endpackage
